/* heap_pkg.sv */
`default_nettype none

package heap_pkg;

   localparam int LEVELS    = 4;
   localparam int PRIO_W    = 16;
   localparam int DATA_W    = 8;
   localparam int CAP_W     = LEVELS;             // counts up to HEAP_SIZE
   localparam int ADDR_W    = LEVELS;             // 1-based node index
   localparam int HEAP_SIZE = 2 ** LEVELS - 1;

   typedef enum logic [1:0] {
      NOP     = 2'd0,
      ENQ     = 2'd1,
      DEQ_MIN = 2'd2
   } heap_op_t;

   // one node of the tree
   typedef struct packed {
      logic              active;
      logic [CAP_W-1:0]  capacity;   // free slots in this subtree, node included
      logic [PRIO_W-1:0] prio;
      logic [DATA_W-1:0] data;
   } heap_entry_t;

   // operation travelling down the levels
   typedef struct packed {
      heap_op_t          op;
      logic [ADDR_W-1:0] pos;
      logic [PRIO_W-1:0] prio;        // entry carried down by an ENQ
      logic [DATA_W-1:0] data;
   } level_token_t;

   typedef struct packed {
      logic              en;
      logic [ADDR_W-1:0] addr;
      heap_entry_t       entry;
   } mem_wr_t;

endpackage

`default_nettype wire

/* heap_root.sv */
`timescale 1ns/1ps
`default_nettype none

module heap_root (
   input  logic                        clk,
   input  logic                        rstn,
   input  heap_pkg::heap_op_t          in_op,
   input  logic [heap_pkg::PRIO_W-1:0] in_prio,
   input  logic [heap_pkg::DATA_W-1:0] in_data,
   output logic                        ready,
   output logic [heap_pkg::PRIO_W-1:0] out_prio,
   output logic [heap_pkg::DATA_W-1:0] out_data,
   output logic                        out_valid,
   output logic [heap_pkg::CAP_W-1:0]  capacity,
   output heap_pkg::level_token_t      root_tok,
   output heap_pkg::heap_entry_t       root_entry,
   input  heap_pkg::mem_wr_t           wr_cur
);
   import heap_pkg::*;

   heap_entry_t root_q;
   heap_entry_t root_next;
   logic        busy_q;
   logic        accept;
   logic        deq_wr;

   assign ready  = ~busy_q;
   assign accept = (in_op != NOP) && ready;
   // a DEQ_MIN on an empty heap leaves the root alone
   assign deq_wr = accept && (in_op == DEQ_MIN) && root_q.active;

   always_comb begin
      root_tok.op   = accept ? in_op : NOP;
      root_tok.pos  = ADDR_W'(1);
      root_tok.prio = in_prio;
      root_tok.data = in_data;
   end

   // level 0 result has priority over the dequeue invalidation
   always_comb begin
      root_next = root_q;
      if (wr_cur.en) begin
         root_next = wr_cur.entry;
      end else if (deq_wr) begin
         root_next.active   = 1'b0;
         root_next.capacity = root_q.capacity + CAP_W'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy_q          <= 1'b0;
         root_q.active   <= 1'b0;
         root_q.capacity <= CAP_W'(HEAP_SIZE);
      end else begin
         busy_q <= accept;   // one idle cycle after every op
         root_q <= root_next;
      end
   end

   assign root_entry = root_q;
   assign out_prio   = root_q.prio;
   assign out_data   = root_q.data;
   assign out_valid  = root_q.active;
   assign capacity   = root_q.capacity;

   a_enq_not_full: assert property (@(posedge clk) disable iff (!rstn)
      (accept && in_op == ENQ) |-> (root_q.capacity != '0));

   // level 0 only writes back while ready is low
   a_root_single_wr: assert property (@(posedge clk) disable iff (!rstn)
      !(wr_cur.en && deq_wr));

endmodule

`default_nettype wire

/* heap_level.sv */
`timescale 1ns/1ps
`default_nettype none

module heap_level #(
   parameter int LEVEL = 0
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  heap_pkg::level_token_t tok_in,
   input  heap_pkg::heap_entry_t  cur_entry,
   input  heap_pkg::heap_entry_t  left_entry,
   input  heap_pkg::heap_entry_t  right_entry,
   output heap_pkg::level_token_t tok_out,
   output heap_pkg::mem_wr_t      wr_cur,
   output heap_pkg::mem_wr_t      wr_child
);
   import heap_pkg::*;

   level_token_t      tok_q;
   heap_entry_t       kid_l;
   heap_entry_t       kid_r;
   heap_entry_t       pick;
   logic              take_left;
   logic [ADDR_W-1:0] left_pos;
   logic [ADDR_W-1:0] right_pos;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         tok_q.op <= NOP;
      end else begin
         tok_q <= tok_in;
      end
   end

   assign left_pos  = tok_q.pos << 1;
   assign right_pos = (tok_q.pos << 1) | ADDR_W'(1);

   // nothing hangs below the last level
   assign kid_l = (LEVEL == LEVELS - 1) ? heap_entry_t'('0) : left_entry;
   assign kid_r = (LEVEL == LEVELS - 1) ? heap_entry_t'('0) : right_entry;

   // smaller active child, left on a tie
   assign take_left = kid_l.active && (!kid_r.active || (kid_l.prio <= kid_r.prio));
   assign pick      = take_left ? kid_l : kid_r;

   always_comb begin
      tok_out    = tok_q;
      tok_out.op = NOP;
      tok_out.pos = left_pos;

      wr_cur.en    = 1'b0;
      wr_cur.addr  = tok_q.pos;
      wr_cur.entry = cur_entry;

      wr_child.en    = 1'b0;
      wr_child.addr  = left_pos;
      wr_child.entry = pick;

      case (tok_q.op)
         ENQ: begin
            wr_cur.en             = 1'b1;
            wr_cur.entry.capacity = cur_entry.capacity - CAP_W'(1);
            if (!cur_entry.active) begin
               // free node, the entry settles here
               wr_cur.entry.active = 1'b1;
               wr_cur.entry.prio   = tok_q.prio;
               wr_cur.entry.data   = tok_q.data;
            end else begin
               tok_out.op  = ENQ;
               tok_out.pos = (kid_l.capacity != '0) ? left_pos : right_pos;
               if (tok_q.prio < cur_entry.prio) begin
                  wr_cur.entry.prio = tok_q.prio;     // swap, old entry goes down
                  wr_cur.entry.data = tok_q.data;
                  tok_out.prio      = cur_entry.prio;
                  tok_out.data      = cur_entry.data;
               end
            end
         end

         DEQ_MIN: begin
            // node is a hole here, refill it from below
            if (kid_l.active || kid_r.active) begin
               wr_cur.en           = 1'b1;
               wr_cur.entry.active = 1'b1;
               wr_cur.entry.prio   = pick.prio;
               wr_cur.entry.data   = pick.data;

               wr_child.en             = 1'b1;
               wr_child.addr           = take_left ? left_pos : right_pos;
               wr_child.entry.active   = 1'b0;
               wr_child.entry.capacity = pick.capacity + CAP_W'(1);

               tok_out.op  = DEQ_MIN;
               tok_out.pos = take_left ? left_pos : right_pos;
            end
         end

         default: begin
         end
      endcase

      if (LEVEL == LEVELS - 1) begin
         tok_out.op = NOP;
      end
   end

endmodule

`default_nettype wire

/* level_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module level_mem #(
   parameter int LEVEL = 1
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  heap_pkg::level_token_t tok_self,
   input  heap_pkg::level_token_t tok_parent,
   output heap_pkg::heap_entry_t  cur_entry,
   output heap_pkg::heap_entry_t  left_entry,
   output heap_pkg::heap_entry_t  right_entry,
   input  heap_pkg::mem_wr_t      wr_cur,
   input  heap_pkg::mem_wr_t      wr_child
);
   import heap_pkg::*;

   localparam int ROWS  = 2 ** (LEVEL - 1);            // sibling pairs at this level
   localparam int ROW_W = (LEVEL > 1) ? LEVEL - 1 : 1;

   heap_entry_t      bank [2][ROWS];   // bank 0 even positions, bank 1 odd
   heap_entry_t      rd_q [2];
   heap_entry_t      init_entry;
   mem_wr_t          wr;
   logic             self_act;
   logic             parent_act;
   logic [ROW_W-1:0] rd_row;
   logic [ROW_W-1:0] wr_row;
   logic             rd_odd_q;

   // row of the sibling pair below a given parent index
   function automatic logic [ROW_W-1:0] pair_row(logic [ADDR_W-1:0] parent);
      return ROW_W'(int'(parent) & (ROWS - 1));
   endfunction

   assign init_entry.active   = 1'b0;
   assign init_entry.capacity = CAP_W'(2 ** (LEVELS - LEVEL) - 1);
   assign init_entry.prio     = '0;
   assign init_entry.data     = '0;

   assign self_act   = (tok_self.op != NOP);
   assign parent_act = (tok_parent.op != NOP);

   // own level reads one node, parent level reads the pair below it
   assign rd_row = self_act ? pair_row(tok_self.pos >> 1) : pair_row(tok_parent.pos);

   assign wr     = wr_cur.en ? wr_cur : wr_child;
   assign wr_row = pair_row(wr.addr >> 1);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int b = 0; b < 2; b++) begin
            for (int r = 0; r < ROWS; r++) begin
               bank[b][r] <= init_entry;
            end
         end
      end else if (wr.en) begin
         bank[wr.addr[0]][wr_row] <= wr.entry;
      end
   end

   always_ff @(posedge clk) begin
      for (int b = 0; b < 2; b++) begin
         if (wr.en && (wr.addr[0] == 1'(b)) && (wr_row == rd_row)) begin
            rd_q[b] <= wr.entry;   // write in the same cycle wins
         end else begin
            rd_q[b] <= bank[b][rd_row];
         end
      end
      rd_odd_q <= tok_self.pos[0];
   end

   assign left_entry  = rd_q[0];
   assign right_entry = rd_q[1];
   assign cur_entry   = rd_odd_q ? rd_q[1] : rd_q[0];

   // ops enter two cycles apart so two adjacent levels never read together
   a_one_reader: assert property (@(posedge clk) disable iff (!rstn)
      !(self_act && parent_act));

   a_one_writer: assert property (@(posedge clk) disable iff (!rstn)
      !(wr_cur.en && wr_child.en));

endmodule

`default_nettype wire

/* prio_heap.sv */
`timescale 1ns/1ps
`default_nettype none

module prio_heap (
   input  logic                        clk,
   input  logic                        rstn,
   input  heap_pkg::heap_op_t          in_op,
   input  logic [heap_pkg::PRIO_W-1:0] in_prio,
   input  logic [heap_pkg::DATA_W-1:0] in_data,
   output logic                        ready,
   output logic [heap_pkg::PRIO_W-1:0] out_prio,
   output logic [heap_pkg::DATA_W-1:0] out_data,
   output logic                        out_valid,
   output logic [heap_pkg::CAP_W-1:0]  capacity
);
   import heap_pkg::*;

   level_token_t tok      [LEVELS];     // tok[k] enters level k
   heap_entry_t  cur_e    [LEVELS];     // node under the token at level k
   heap_entry_t  left_e   [LEVELS-1];   // children seen by level k
   heap_entry_t  right_e  [LEVELS-1];
   mem_wr_t      wr_cur_a [LEVELS];
   mem_wr_t      wr_kid_a [LEVELS-1];

   heap_root u_root (
      .clk        (clk),
      .rstn       (rstn),
      .in_op      (in_op),
      .in_prio    (in_prio),
      .in_data    (in_data),
      .ready      (ready),
      .out_prio   (out_prio),
      .out_data   (out_data),
      .out_valid  (out_valid),
      .capacity   (capacity),
      .root_tok   (tok[0]),
      .root_entry (cur_e[0]),
      .wr_cur     (wr_cur_a[0])
   );

   for (genvar g = 0; g < LEVELS; g++) begin : g_level
      if (g < LEVELS - 1) begin : g_inner
         heap_level #(.LEVEL(g)) u_level (
            .clk         (clk),
            .rstn        (rstn),
            .tok_in      (tok[g]),
            .cur_entry   (cur_e[g]),
            .left_entry  (left_e[g]),
            .right_entry (right_e[g]),
            .tok_out     (tok[g+1]),
            .wr_cur      (wr_cur_a[g]),
            .wr_child    (wr_kid_a[g])
         );
      end else begin : g_last
         heap_level #(.LEVEL(g)) u_level (
            .clk         (clk),
            .rstn        (rstn),
            .tok_in      (tok[g]),
            .cur_entry   (cur_e[g]),
            .left_entry  (),
            .right_entry (),
            .tok_out     (),
            .wr_cur      (wr_cur_a[g]),
            .wr_child    ()
         );
      end
   end

   for (genvar k = 1; k < LEVELS; k++) begin : g_mem
      level_mem #(.LEVEL(k)) u_mem (
         .clk         (clk),
         .rstn        (rstn),
         .tok_self    (tok[k]),
         .tok_parent  (tok[k-1]),
         .cur_entry   (cur_e[k]),
         .left_entry  (left_e[k-1]),
         .right_entry (right_e[k-1]),
         .wr_cur      (wr_cur_a[k]),
         .wr_child    (wr_kid_a[k-1])
      );
   end

endmodule

`default_nettype wire

/* tb_tasks.svh */
`default_nettype none

// one clock that ends at the drive point after the edge
task automatic step();
   @(posedge clk);
   #DRIVE_DELAY;
endtask

task automatic wait_ready();
   int n = 0;
   while (!ready) begin
      step();
      n++;
      assert (n < READY_LIMIT) else begin
         $display("ready stayed low for %0d cycles", n);
         fail_run();
      end
   end
endtask

task automatic issue_op(input heap_op_t op, input logic [PRIO_W-1:0] prio,
                        input logic [DATA_W-1:0] data);
   wait_ready();
   in_op   = op;
   in_prio = prio;
   in_data = data;
   step();
   in_op   = NOP;   // strobe lasts one cycle
endtask

// outputs settle once ready is back
task automatic check_state();
   int n;
   n = model_q.size();
   wait_ready();
   assert (out_valid == (n != 0))
      else value_error("out_valid", 32'(out_valid), 32'(n != 0));
   assert (capacity == CAP_W'(HEAP_SIZE - n))
      else value_error("capacity", 32'(capacity), 32'(HEAP_SIZE - n));
   if (n != 0) begin
      assert (out_prio == PRIO_W'(model_q[0]))
         else value_error("out_prio", 32'(out_prio), 32'(model_q[0]));
   end
endtask

task automatic enq(input logic [PRIO_W-1:0] prio, input logic [DATA_W-1:0] data);
   int i = 0;
   issue_op(ENQ, prio, data);
   while (i < model_q.size() && model_q[i] <= int'(prio)) begin
      i++;
   end
   model_q.insert(i, int'(prio));
   check_state();
endtask

// returns what the outputs showed when the DEQ_MIN was accepted
task automatic deq(output logic [PRIO_W-1:0] prio, output logic [DATA_W-1:0] data);
   logic was_valid;
   wait_ready();
   was_valid = out_valid;
   prio      = out_prio;
   data      = out_data;
   issue_op(DEQ_MIN, '0, '0);
   assert (was_valid == (model_q.size() != 0))
      else value_error("out_valid", 32'(was_valid), 32'(model_q.size() != 0));
   if (model_q.size() != 0) begin
      assert (prio == PRIO_W'(model_q[0]))
         else value_error("out_prio", 32'(prio), 32'(model_q[0]));
      void'(model_q.pop_front());
   end
   check_state();
endtask

task automatic check_reset_state();
   assert (ready == 1'b1) else value_error("ready", 32'(ready), 32'd1);
   assert (out_valid == 1'b0) else value_error("out_valid", 32'(out_valid), 32'd0);
   assert (capacity == CAP_W'(HEAP_SIZE))
      else value_error("capacity", 32'(capacity), 32'(HEAP_SIZE));
endtask

task automatic insert_descending();
   logic [PRIO_W-1:0] p;
   logic [DATA_W-1:0] d;
   for (int i = 0; i < 6; i++) begin
      p = PRIO_W'(32'h9000 - i * 32'h1000);
      enq(p, DATA_W'(i));
      assert (out_prio == p) else value_error("out_prio", 32'(out_prio), 32'(p));
      assert (out_data == DATA_W'(i)) else value_error("out_data", 32'(out_data), 32'(i));
   end
   for (int i = 0; i < 6; i++) begin
      deq(p, d);
      assert (d == DATA_W'(5 - i)) else value_error("out_data", 32'(d), 32'(5 - i));
   end
endtask

task automatic fill_and_drain();
   logic [PRIO_W-1:0] p;
   logic [PRIO_W-1:0] last;
   logic [DATA_W-1:0] d;
   for (int i = 0; i < HEAP_SIZE; i++) begin
      enq(next_rand(), DATA_W'(i));
   end
   last = '0;
   for (int i = 0; i < HEAP_SIZE; i++) begin
      deq(p, d);
      assert (p >= last) else begin
         $display("dequeue order broken, 0x%0h came after 0x%0h", p, last);
         fail_run();
      end
      last = p;
   end
endtask

task automatic deq_when_empty();
   logic [PRIO_W-1:0] p;
   logic [DATA_W-1:0] d;
   deq(p, d);   // model is empty so deq expects no change
endtask

task automatic equal_priorities();
   logic [PRIO_W-1:0] p;
   logic [DATA_W-1:0] d;
   logic [7:0]        seen;
   seen = '0;
   for (int i = 0; i < 8; i++) begin
      enq(16'h0abc, DATA_W'(8'h40 + i));
   end
   for (int i = 0; i < 8; i++) begin
      deq(p, d);
      assert (d[7:3] == 5'h08 && !seen[d[2:0]]) else begin
         $display("data 0x%0h was dequeued twice or never stored", d);
         fail_run();
      end
      seen[d[2:0]] = 1'b1;
   end
endtask

task automatic mixed_ops();
   logic [PRIO_W-1:0] r;
   logic [PRIO_W-1:0] p;
   logic [DATA_W-1:0] d;
   for (int i = 0; i < RAND_OPS; i++) begin
      r = next_rand();
      if (model_q.size() == 0 || (model_q.size() < HEAP_SIZE && r[0])) begin
         enq(next_rand(), DATA_W'(i));
      end else begin
         deq(p, d);
      end
   end
   while (model_q.size() != 0) begin
      deq(p, d);
   end
endtask

`default_nettype wire

/* tb_prio_heap.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_prio_heap;
   import heap_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DELAY  = 2;
   localparam int RESET_CYCLES = 16;
   localparam int RAND_OPS     = 40;
   localparam int READY_LIMIT  = 8;     // cycles ready may stay low
   // descending, fill/drain, empty deq, equal prio, interleaved plus its drain
   localparam int TOTAL_OPS    = 12 + 2 * HEAP_SIZE + 1 + 16 + RAND_OPS + HEAP_SIZE;

   logic              clk;
   logic              rstn;
   heap_op_t          in_op;
   logic [PRIO_W-1:0] in_prio;
   logic [DATA_W-1:0] in_data;
   logic              ready;
   logic [PRIO_W-1:0] out_prio;
   logic [DATA_W-1:0] out_data;
   logic              out_valid;
   logic [CAP_W-1:0]  capacity;

   logic [31:0] lcg_state;
   int          model_q[$];   // priorities held by the heap, ascending

   prio_heap dut0 (
      .clk       (clk),
      .rstn      (rstn),
      .in_op     (in_op),
      .in_prio   (in_prio),
      .in_data   (in_data),
      .ready     (ready),
      .out_prio  (out_prio),
      .out_data  (out_data),
      .out_valid (out_valid),
      .capacity  (capacity)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // watchdog, four cycles per op is well above the real cost
   initial begin
      #((TOTAL_OPS * 4 + RESET_CYCLES) * CLK_PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      fail_run();
   end

   task automatic fail_run();
      $display("** FAIL **");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic value_error(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      fail_run();
   endtask

   function automatic logic [PRIO_W-1:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];   // upper bits have the longer period
   endfunction

   initial begin
      rstn      = 1'b0;
      in_op     = NOP;
      in_prio   = '0;
      in_data   = '0;
      lcg_state = 32'd47;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rstn = 1'b1;
      step();

      check_reset_state();
      insert_descending();
      fill_and_drain();
      deq_when_empty();
      equal_priorities();
      mixed_ops();

      $display("** PASS **");
      $finish;
   end

   `include "tb_tasks.svh"

endmodule

`default_nettype wire

/* prio_heap.f */
+incdir+.
heap_pkg.sv
heap_root.sv
heap_level.sv
level_mem.sv
prio_heap.sv
tb_prio_heap.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_prio_heap
FILELIST  ?= prio_heap.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
